//--- chip_io.f
src/pad_cfg_pkg.sv
src/frame_ctrl_pkg.sv
src/xres_filter.sv
src/gpio_pad.sv
src/mprj_io.sv
src/mgmt_pads.sv
src/chip_io_alt.sv
sim/tb_chip_io_alt.sv

//--- sim/tb_chip_io_alt.sv
`default_nettype none

module tb_chip_io_alt;

	localparam int NDIG = pad_cfg_pkg::DIGITAL_PADS;
	localparam int NRING = pad_cfg_pkg::MPRJ_IO_PADS;
	localparam int NANA = pad_cfg_pkg::ANALOG_PADS;
	localparam int NFILT = frame_ctrl_pkg::XRES_FILTER_CYCLES;

	// Test lengths in clock cycles
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_ITERS = 4;    // Per dm code
	localparam int INPUT_STEPS = 12;
	localparam int HOLD_STEPS = 6;
	localparam int ANALOG_ITERS = 8;
	localparam int MGMT_ITERS = 16;
	localparam int TEST_CYCLES = (RESET_CYCLES + 2 * NFILT + 4) + 8 * DRIVE_ITERS +
		(INPUT_STEPS + 1) + (HOLD_STEPS + 3) + (NDIG + ANALOG_ITERS + 1) + (2 * MGMT_ITERS + 1);
	localparam int TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 4 + 20;

	logic clock, rst_n, resetb;
	logic gpio_out_core, gpio_outenb_core, gpio_inenb_core, gpio_mode0_core, gpio_mode1_core;
	logic flash_csb_core, flash_clk_core, flash_csb_oeb_core, flash_clk_oeb_core;
	logic flash_io0_do_core, flash_io1_do_core, flash_io0_oeb_core, flash_io1_oeb_core;
	logic flash_io0_ieb_core, flash_io1_ieb_core;
	logic [NDIG-1:0] mprj_io_out, mprj_io_oeb, mprj_io_inp_dis, mprj_io_holdover;
	logic [NDIG*3-1:0] mprj_io_dm;
	wire resetb_core_h, clock_core, gpio_in_core, flash_csb, flash_clk;
	wire flash_io0_di_core, flash_io1_di_core;
	wire [NDIG-1:0] mprj_io_in, mprj_io_in_3v3;
	wire [NANA-1:0] mprj_analog;
	wire gpio, flash_io0, flash_io1;
	wire [NRING-1:0] mprj_io;

	// Testbench side of the pads
	logic [NRING-1:0] ring_val, ring_en;
	logic gpio_val, gpio_en, fio0_val, fio0_en, fio1_val, fio1_en;
	logic [31:0] rng_state;
	int checks, errors, cycle_cnt;

	for (genvar g = 0; g < NRING; g++) begin : g_drv
		assign mprj_io[g] = ring_en[g] ? ring_val[g] : 1'bz;
	end
	assign gpio = gpio_en ? gpio_val : 1'bz;
	assign flash_io0 = fio0_en ? fio0_val : 1'bz;
	assign flash_io1 = fio1_en ? fio1_val : 1'bz;

	chip_io_alt chip_io_alt_inst (.*);

	always #2 clock = ~clock;

	// Hang guard
	always @(posedge clock) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		rng_state = xorshift32(rng_state);
		hi = rng_state;
		rng_state = xorshift32(rng_state);
		return {hi, rng_state};
	endfunction

	// Ring position of digital index i past the analog block
	function automatic int pad_index(input int i);
		return (i < pad_cfg_pkg::AREA1_DIGITAL) ? i : i + NANA;
	endfunction

	// Pad level from the drive-mode rule with z where the pad lets go
	function automatic logic expected_pad_bit(input logic [2:0] code, input logic out,
		input logic oeb);
		logic v;
		v = 1'bz;
		case (code)
			3'd6, 3'd7: if (!oeb) v = out;                  // Push-pull
			3'd2, 3'd3: if (!oeb && !out) v = 1'b0;         // Low only
			default: v = 1'bz;                              // Input and analog
		endcase
		return v;
	endfunction

	function automatic logic [NRING-1:0] expected_ring(input logic [NDIG*3-1:0] dm,
		input logic [NDIG-1:0] out, input logic [NDIG-1:0] oeb);
		logic [NRING-1:0] r;
		r = {NRING{1'bz}}; // Analog pads float
		for (int i = 0; i < NDIG; i++)
			r[pad_index(i)] = expected_pad_bit(dm[3*i +: 3], out[i], oeb[i]);
		return r;
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("%s: %s, %0d mismatches", name,
			(errors == err_before) ? "ok" : "errors", errors - err_before);
	endtask

	task automatic reset_and_enable();
		logic [63:0] r;
		r = rand64();
		mprj_io_dm = {NDIG{3'd6}};  // Would drive if enabled
		mprj_io_oeb = '0;
		mprj_io_out = r[NDIG-1:0];
		repeat (RESET_CYCLES - 1) @(negedge clock);
		#1;
		check_value(mprj_io, {NRING{1'bz}}, "ring in reset");
		check_value({gpio, flash_io0, flash_io1, flash_csb, flash_clk}, {5{1'bz}},
			"mgmt pads in reset");
		check_value(resetb_core_h, 1'b0, "core reset during rst_n");
		@(negedge clock);
		rst_n = 1'b1;
		repeat (NFILT - 1) @(negedge clock);
		#1;
		check_value(resetb_core_h, 1'b0, "core reset one edge before release");
		check_value(mprj_io, expected_ring(mprj_io_dm, mprj_io_out, mprj_io_oeb), "ring enabled");
		@(negedge clock);
		#1;
		check_value(resetb_core_h, 1'b1, "core reset released");
		@(negedge clock);
		resetb = 1'b0; // One cycle glitch
		@(negedge clock);
		resetb = 1'b1;
		#1;
		check_value(resetb_core_h, 1'b0, "core reset after glitch");
		repeat (NFILT - 1) @(negedge clock);
		#1;
		check_value(resetb_core_h, 1'b0, "count restarted after glitch");
		@(negedge clock);
		#1;
		check_value(resetb_core_h, 1'b1, "core reset released after glitch");
	endtask

	task automatic drive_modes();
		logic [63:0] r;
		for (int code = 0; code < 8; code++) begin
			for (int it = 0; it < DRIVE_ITERS; it++) begin
				@(negedge clock);
				r = rand64();
				ring_en = '0;
				mprj_io_dm = {NDIG{3'(code)}};
				mprj_io_out = r[NDIG-1:0];
				mprj_io_oeb = r[NDIG+31:32];
				#1;
				check_value(mprj_io, expected_ring(mprj_io_dm, mprj_io_out, mprj_io_oeb),
					$sformatf("ring with dm %0d", code));
			end
		end
	endtask

	task automatic input_paths();
		logic [63:0] r, m;
		logic [NDIG-1:0] dis, ana, exp;
		logic [NDIG-1:0] hist[$];
		for (int step = 0; step < INPUT_STEPS; step++) begin
			@(negedge clock);
			r = rand64();
			m = rand64();
			mprj_io_oeb = '1;
			dis = (step < INPUT_STEPS / 2) ? '0 : m[NDIG-1:0];
			ana = (step < INPUT_STEPS / 2) ? '0 : m[NDIG+31:32];
			for (int i = 0; i < NDIG; i++) begin
				// Spread the three input codes over the pads
				mprj_io_dm[3*i +: 3] = ana[i] ? 3'd0 :
					((step + i) % 3 == 0) ? 3'd1 : ((step + i) % 3 == 1) ? 3'd4 : 3'd5;
				ring_en[pad_index(i)] = 1'b1;
				ring_val[pad_index(i)] = r[i];
			end
			mprj_io_inp_dis = dis;
			exp = r[NDIG-1:0] & ~dis & ~ana;
			#1;
			check_value(mprj_io_in_3v3, exp, $sformatf("io_in_3v3 step %0d", step));
			hist.push_back(exp);
			if (hist.size() > 2)
				check_value(mprj_io_in, hist.pop_front(), $sformatf("io_in step %0d", step));
		end
		@(negedge clock);
		ring_en = '0;
		mprj_io_inp_dis = '0;
	endtask

	task automatic hold_outputs();
		logic [63:0] r;
		logic [NDIG-1:0] held_out, held_oeb, hm, sel_out, sel_oeb;
		@(negedge clock);
		r = rand64();
		mprj_io_dm = {NDIG{3'd6}};
		mprj_io_holdover = '0;
		held_out = r[NDIG-1:0];
		held_oeb = r[NDIG+31:32];
		mprj_io_out = held_out;
		mprj_io_oeb = held_oeb;
		r = rand64();
		hm = r[NDIG-1:0] | 1'b1;    // Mix of held and live pads
		for (int step = 0; step < HOLD_STEPS + 2; step++) begin
			@(negedge clock);
			r = rand64();
			mprj_io_holdover = (step < HOLD_STEPS) ? hm : '0;
			mprj_io_out = r[NDIG-1:0];
			mprj_io_oeb = r[NDIG+31:32];
			sel_out = (mprj_io_out & ~mprj_io_holdover) | (held_out & mprj_io_holdover);
			sel_oeb = (mprj_io_oeb & ~mprj_io_holdover) | (held_oeb & mprj_io_holdover);
			#1;
			check_value(mprj_io, expected_ring(mprj_io_dm, sel_out, sel_oeb),
				$sformatf("ring hold step %0d", step));
		end
	endtask

	task automatic pad_mapping();
		logic [63:0] r;
		logic [NRING-1:0] exp;
		for (int i = 0; i < NDIG; i++) begin
			@(negedge clock);
			mprj_io_dm = {NDIG{3'd6}};
			mprj_io_oeb = '0;
			mprj_io_out = '0;
			mprj_io_out[i] = 1'b1;   // Walking one
			exp = {NRING{1'bz}};
			for (int j = 0; j < NDIG; j++)
				exp[pad_index(j)] = (j == i);
			#1;
			check_value(mprj_io, exp, $sformatf("walking one on digital %0d", i));
		end
		for (int it = 0; it < ANALOG_ITERS; it++) begin
			@(negedge clock);
			r = rand64();
			mprj_io_oeb = '1;
			ring_en[pad_cfg_pkg::ANALOG_BASE +: NANA] = '1;
			ring_val[pad_cfg_pkg::ANALOG_BASE +: NANA] = r[NANA-1:0];
			#1;
			check_value(mprj_analog, r[NANA-1:0], "analog taps");
		end
		@(negedge clock);
		ring_en = '0;
	endtask

	task automatic mgmt_pad_checks();
		logic [63:0] r;
		logic [2:0] gcode;
		logic gdrv, exp_io0, exp_io1, exp_gpio;
		for (int it = 0; it < MGMT_ITERS; it++) begin
			@(negedge clock);
			r = rand64();
			{flash_csb_core, flash_csb_oeb_core, flash_clk_core, flash_clk_oeb_core} = r[3:0];
			{flash_io0_do_core, flash_io0_oeb_core, flash_io0_ieb_core, fio0_val} = r[7:4];
			{flash_io1_do_core, flash_io1_oeb_core, flash_io1_ieb_core, fio1_val} = r[11:8];
			{gpio_out_core, gpio_outenb_core, gpio_inenb_core} = r[14:12];
			{gpio_mode0_core, gpio_mode1_core, gpio_val} = r[17:15];
			fio0_en = flash_io0_oeb_core;  // Drive only when the pad lets go
			fio1_en = flash_io1_oeb_core;
			gcode = {gpio_mode1_core, gpio_mode1_core, gpio_mode0_core};
			gdrv = expected_pad_bit(gcode, gpio_out_core, gpio_outenb_core);
			gpio_en = (gdrv === 1'bz);
			exp_io0 = flash_io0_oeb_core ? fio0_val : flash_io0_do_core;
			exp_io1 = flash_io1_oeb_core ? fio1_val : flash_io1_do_core;
			exp_gpio = gpio_en ? gpio_val : gdrv;
			#1;
			check_value(flash_csb, flash_csb_oeb_core ? 1'bz : flash_csb_core, "flash_csb");
			check_value(flash_clk, flash_clk_oeb_core ? 1'bz : flash_clk_core, "flash_clk");
			check_value(flash_io0, exp_io0, "flash_io0 pad");
			check_value(flash_io1, exp_io1, "flash_io1 pad");
			check_value(flash_io0_di_core, flash_io0_ieb_core ? 1'b0 : exp_io0, "flash_io0 di");
			check_value(flash_io1_di_core, flash_io1_ieb_core ? 1'b0 : exp_io1, "flash_io1 di");
			check_value(gpio, exp_gpio, $sformatf("gpio pad, mode %0d", gcode));
			check_value(gpio_in_core, (gcode == 3'd0 || gpio_inenb_core) ? 1'b0 : exp_gpio,
				"gpio_in_core");
			check_value(clock_core, 1'b0, "clock_core low phase");
			@(posedge clock);
			#1;
			check_value(clock_core, 1'b1, "clock_core high phase");
		end
		@(negedge clock);
		{gpio_en, fio0_en, fio1_en} = '0;
	endtask

	initial begin
		int err0;
		clock = 1'b0;
		rst_n = 1'b0;
		resetb = 1'b1;
		rng_state = 32'd15495;
		checks = 0;
		errors = 0;
		cycle_cnt = 0;
		{gpio_out_core, gpio_outenb_core, gpio_inenb_core, gpio_mode0_core} = 4'b1000;
		gpio_mode1_core = 1'b1;
		{flash_csb_core, flash_clk_core, flash_csb_oeb_core, flash_clk_oeb_core} = 4'b0;
		{flash_io0_do_core, flash_io1_do_core, flash_io0_oeb_core, flash_io1_oeb_core} = 4'b0;
		{flash_io0_ieb_core, flash_io1_ieb_core} = 2'b0;
		mprj_io_out = '0;
		mprj_io_oeb = '1;
		mprj_io_inp_dis = '0;
		mprj_io_holdover = '0;
		mprj_io_dm = '0;
		{ring_val, ring_en} = '0;
		{gpio_val, gpio_en, fio0_val, fio0_en, fio1_val, fio1_en} = '0;

		err0 = errors;
		reset_and_enable();
		report_test("reset_and_enable", err0);
		err0 = errors;
		drive_modes();
		report_test("drive_modes", err0);
		err0 = errors;
		input_paths();
		report_test("input_paths", err0);
		err0 = errors;
		hold_outputs();
		report_test("hold_outputs", err0);
		err0 = errors;
		pad_mapping();
		report_test("pad_mapping", err0);
		err0 = errors;
		mgmt_pad_checks();
		report_test("mgmt_pad_checks", err0);

		$display("Summary: 6 tests, %0d checks, %0d mismatches", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/chip_io_alt.sv
`default_nettype none

module chip_io_alt (
	// Package pins
	inout  wire  gpio,
	input  wire  clock,
	input  wire  resetb,
	output logic flash_csb,
	output logic flash_clk,
	inout  wire  flash_io0,
	inout  wire  flash_io1,
	// Core side
	input  wire  rst_n,            // Power-on reset
	output logic resetb_core_h,
	output logic clock_core,
	input  wire  gpio_out_core,
	output logic gpio_in_core,
	input  wire  gpio_mode0_core,
	input  wire  gpio_mode1_core,
	input  wire  gpio_outenb_core,
	input  wire  gpio_inenb_core,
	input  wire  flash_csb_core,
	input  wire  flash_clk_core,
	input  wire  flash_csb_oeb_core,
	input  wire  flash_clk_oeb_core,
	input  wire  flash_io0_oeb_core,
	input  wire  flash_io1_oeb_core,
	input  wire  flash_io0_ieb_core,
	input  wire  flash_io1_ieb_core,
	input  wire  flash_io0_do_core,
	input  wire  flash_io1_do_core,
	output logic flash_io0_di_core,
	output logic flash_io1_di_core,
	// User pads, the full ring both digital and analog
	inout  wire  [pad_cfg_pkg::MPRJ_IO_PADS-1:0]   mprj_io,
	// Digital pads only, in digital index order
	input  wire  [pad_cfg_pkg::DIGITAL_PADS-1:0]   mprj_io_out,
	input  wire  [pad_cfg_pkg::DIGITAL_PADS-1:0]   mprj_io_oeb,
	input  wire  [pad_cfg_pkg::DIGITAL_PADS-1:0]   mprj_io_inp_dis,
	input  wire  [pad_cfg_pkg::DIGITAL_PADS-1:0]   mprj_io_holdover,
	input  wire  [pad_cfg_pkg::DIGITAL_PADS*3-1:0] mprj_io_dm,
	output logic [pad_cfg_pkg::DIGITAL_PADS-1:0]   mprj_io_in,
	output logic [pad_cfg_pkg::DIGITAL_PADS-1:0]   mprj_io_in_3v3,
	// Straight-through analog pads, pad to core
	output logic [pad_cfg_pkg::ANALOG_PADS-1:0]    mprj_analog
);

	xres_filter xres_filter_inst (
		.clock         (clock),
		.rst_n         (rst_n),
		.resetb        (resetb),
		.resetb_core_h (resetb_core_h)
	);

	mgmt_pads mgmt_pads_inst (
		.clock              (clock),
		.rst_n              (rst_n),
		.gpio_out_core      (gpio_out_core),
		.gpio_outenb_core   (gpio_outenb_core),
		.gpio_inenb_core    (gpio_inenb_core),
		.gpio_mode0_core    (gpio_mode0_core),
		.gpio_mode1_core    (gpio_mode1_core),
		.flash_csb_core     (flash_csb_core),
		.flash_clk_core     (flash_clk_core),
		.flash_csb_oeb_core (flash_csb_oeb_core),
		.flash_clk_oeb_core (flash_clk_oeb_core),
		.flash_io0_do_core  (flash_io0_do_core),
		.flash_io1_do_core  (flash_io1_do_core),
		.flash_io0_oeb_core (flash_io0_oeb_core),
		.flash_io1_oeb_core (flash_io1_oeb_core),
		.flash_io0_ieb_core (flash_io0_ieb_core),
		.flash_io1_ieb_core (flash_io1_ieb_core),
		.gpio               (gpio),
		.flash_io0          (flash_io0),
		.flash_io1          (flash_io1),
		.flash_csb          (flash_csb),
		.flash_clk          (flash_clk),
		.clock_core         (clock_core),
		.gpio_in_core       (gpio_in_core),
		.flash_io0_di_core  (flash_io0_di_core),
		.flash_io1_di_core  (flash_io1_di_core)
	);

	// Digital pads skip the analog block: area 2 on top, area 1 below
	mprj_io mprj_io_inst (
		.clock     (clock),
		.rst_n     (rst_n),
		.io_out    (mprj_io_out),
		.oeb       (mprj_io_oeb),
		.inp_dis   (mprj_io_inp_dis),
		.holdover  (mprj_io_holdover),
		.dm        (mprj_io_dm),
		.io        ({mprj_io[pad_cfg_pkg::MPRJ_IO_PADS-1:
		                     pad_cfg_pkg::ANALOG_BASE+pad_cfg_pkg::ANALOG_PADS],
		             mprj_io[pad_cfg_pkg::AREA1_DIGITAL-1:0]}),
		.io_in     (mprj_io_in),
		.io_in_3v3 (mprj_io_in_3v3)
	);

	// Analog taps
	assign mprj_analog = mprj_io[pad_cfg_pkg::ANALOG_BASE+pad_cfg_pkg::ANALOG_PADS-1:
	                             pad_cfg_pkg::ANALOG_BASE];

endmodule

`default_nettype wire

//--- src/mgmt_pads.sv
`default_nettype none

module mgmt_pads (
	input  wire  clock,
	input  wire  rst_n,
	// Management GPIO
	input  wire  gpio_out_core,
	input  wire  gpio_outenb_core,
	input  wire  gpio_inenb_core,
	input  wire  gpio_mode0_core,
	input  wire  gpio_mode1_core,
	// Flash SPI, core side
	input  wire  flash_csb_core,
	input  wire  flash_clk_core,
	input  wire  flash_csb_oeb_core,
	input  wire  flash_clk_oeb_core,
	input  wire  flash_io0_do_core,
	input  wire  flash_io1_do_core,
	input  wire  flash_io0_oeb_core,
	input  wire  flash_io1_oeb_core,
	input  wire  flash_io0_ieb_core,
	input  wire  flash_io1_ieb_core,
	// Pads
	inout  wire  gpio,
	inout  wire  flash_io0,
	inout  wire  flash_io1,
	output logic flash_csb,
	output logic flash_clk,
	// Back to the core
	output logic clock_core,
	output logic gpio_in_core,
	output logic flash_io0_di_core,
	output logic flash_io1_di_core
);

	logic [2:0] gpio_dm;

	assign clock_core = clock; // Clock input pad

	// mode1 feeds both upper bits, so only codes 0, 1, 6 and 7 are reachable
	assign gpio_dm = {gpio_mode1_core, gpio_mode1_core, gpio_mode0_core};

	gpio_pad gpio_pad_inst (
		.clock    (clock),
		.rst_n    (rst_n),
		.out      (gpio_out_core),
		.oeb      (gpio_outenb_core),
		.inp_dis  (gpio_inenb_core),
		.holdover (1'b0),
		.dm       (gpio_dm),
		.pad      (gpio),
		.in       (),              // Core samples the raw path
		.in_3v3   (gpio_in_core)
	);

	// Flash data pads, strong drive with direction from oeb and ieb
	gpio_pad flash_io0_pad_inst (
		.clock    (clock),
		.rst_n    (rst_n),
		.out      (flash_io0_do_core),
		.oeb      (flash_io0_oeb_core),
		.inp_dis  (flash_io0_ieb_core),
		.holdover (1'b0),
		.dm       (pad_cfg_pkg::DM_STRONG),
		.pad      (flash_io0),
		.in       (),
		.in_3v3   (flash_io0_di_core)
	);

	gpio_pad flash_io1_pad_inst (
		.clock    (clock),
		.rst_n    (rst_n),
		.out      (flash_io1_do_core),
		.oeb      (flash_io1_oeb_core),
		.inp_dis  (flash_io1_ieb_core),
		.holdover (1'b0),
		.dm       (pad_cfg_pkg::DM_STRONG),
		.pad      (flash_io1),
		.in       (),
		.in_3v3   (flash_io1_di_core)
	);

	// Output-only flash pads
	assign flash_csb = (rst_n && !flash_csb_oeb_core) ? flash_csb_core : 1'bz;
	assign flash_clk = (rst_n && !flash_clk_oeb_core) ? flash_clk_core : 1'bz;

endmodule

`default_nettype wire

//--- src/mprj_io.sv
`default_nettype none

module mprj_io (
	input  wire  clock,
	input  wire  rst_n,
	input  wire  [pad_cfg_pkg::DIGITAL_PADS-1:0]   io_out,
	input  wire  [pad_cfg_pkg::DIGITAL_PADS-1:0]   oeb,
	input  wire  [pad_cfg_pkg::DIGITAL_PADS-1:0]   inp_dis,
	input  wire  [pad_cfg_pkg::DIGITAL_PADS-1:0]   holdover,
	input  wire  [pad_cfg_pkg::DIGITAL_PADS*3-1:0] dm,       // Three bits per pad
	inout  wire  [pad_cfg_pkg::DIGITAL_PADS-1:0]   io,
	output logic [pad_cfg_pkg::DIGITAL_PADS-1:0]   io_in,
	output logic [pad_cfg_pkg::DIGITAL_PADS-1:0]   io_in_3v3
);

	// One GPIO cell per digital user pad
	// Digital index order here, the top level maps it onto the ring
	for (genvar i = 0; i < pad_cfg_pkg::DIGITAL_PADS; i++) begin : g_pad
		gpio_pad gpio_pad_inst (
			.clock    (clock),
			.rst_n    (rst_n),
			.out      (io_out[i]),
			.oeb      (oeb[i]),
			.inp_dis  (inp_dis[i]),
			.holdover (holdover[i]),
			.dm       (dm[3*i +: 3]),    // Mode field of pad i
			.pad      (io[i]),
			.in       (io_in[i]),
			.in_3v3   (io_in_3v3[i])
		);
	end

endmodule

`default_nettype wire

//--- src/gpio_pad.sv
`default_nettype none

module gpio_pad (
	input  wire       clock,
	input  wire       rst_n,     // Pad enable, low keeps the pad high-impedance
	input  wire       out,       // Core output value
	input  wire       oeb,       // Output enable, active low
	input  wire       inp_dis,   // Input buffer disable
	input  wire       holdover,  // Freeze output and enable at last captured value
	input  wire [2:0] dm,        // Raw drive mode
	inout  wire       pad,
	output logic      in,        // Synchronised pad input
	output logic      in_3v3     // Raw pad input
);

	pad_cfg_pkg::dm_e mode;
	logic ie;         // Input buffer on
	logic drv_lo_ok;  // Mode may pull the pad low
	logic drv_hi_ok;  // Mode may pull the pad high
	logic hold_out;
	logic hold_oeb;
	logic drv_out;
	logic drv_oeb;
	logic drive_en;
	logic [1:0] sync_q;

	assign mode = pad_cfg_pkg::dm_decode(dm);

	// Permissions per drive mode
	always_comb begin
		ie        = 1'b1;
		drv_lo_ok = 1'b0;
		drv_hi_ok = 1'b0;
		case (mode)
			pad_cfg_pkg::DM_ANALOG: begin
				ie = 1'b0; // Digital input buffer off
			end
			pad_cfg_pkg::DM_OPEN_DRAIN: begin
				drv_lo_ok = 1'b1;
			end
			pad_cfg_pkg::DM_STRONG: begin
				drv_lo_ok = 1'b1;
				drv_hi_ok = 1'b1;
			end
			default: begin
				ie = 1'b1; // Input only
			end
		endcase
	end

	// Hold register tracks the live output until holdover rises
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			hold_out <= 1'b0;
			hold_oeb <= 1'b1;        // Output off
		end else if (!holdover) begin
			hold_out <= out;
			hold_oeb <= oeb;
		end
	end

	assign drv_out  = holdover ? hold_out : out;
	assign drv_oeb  = holdover ? hold_oeb : oeb;
	assign drive_en = rst_n & ~drv_oeb; // rst_n plays the enh role of the real cell

	// Tri-state driver
	assign pad = (drive_en && drv_hi_ok && drv_out)  ? 1'b1 :
	             (drive_en && drv_lo_ok && !drv_out) ? 1'b0 :
	                                                   1'bz;

	// Input path, forced low when the buffer is off
	assign in_3v3 = pad & ie & ~inp_dis;

	// Two-flop synchroniser into the core clock domain
	always_ff @(posedge clock) begin
		sync_q <= {sync_q[0], in_3v3};
	end

	assign in = sync_q[1];

endmodule

`default_nettype wire

//--- src/xres_filter.sv
`default_nettype none

module xres_filter (
	input  wire  clock,
	input  wire  rst_n,         // Power-on reset, stands in for porb_h
	input  wire  resetb,        // External reset pad, active low
	output logic resetb_core_h  // Filtered core reset, active low
);

	frame_ctrl_pkg::xres_state_e state, state_nxt;
	logic [frame_ctrl_pkg::XRES_CNT_W-1:0] hi_cnt, hi_cnt_nxt; // Consecutive high samples

	always_comb begin
		state_nxt  = state;
		hi_cnt_nxt = hi_cnt;

		if (!resetb) begin
			// Any low sample drops the core reset and restarts qualification
			state_nxt  = frame_ctrl_pkg::XRES_ASSERTED;
			hi_cnt_nxt = '0;
		end else begin
			case (state)
				frame_ctrl_pkg::XRES_ASSERTED,
				frame_ctrl_pkg::XRES_QUALIFY: begin
					hi_cnt_nxt = hi_cnt + 1'b1;
					if (hi_cnt == frame_ctrl_pkg::XRES_CNT_LAST)
						state_nxt = frame_ctrl_pkg::XRES_RELEASED; // Last clean sample
					else
						state_nxt = frame_ctrl_pkg::XRES_QUALIFY;
				end
				frame_ctrl_pkg::XRES_RELEASED: begin
					hi_cnt_nxt = hi_cnt; // Saturated at the filter length
				end
				default: begin
					state_nxt  = frame_ctrl_pkg::XRES_ASSERTED;
					hi_cnt_nxt = '0;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state  <= frame_ctrl_pkg::XRES_ASSERTED;
			hi_cnt <= '0;
		end else begin
			state  <= state_nxt;
			hi_cnt <= hi_cnt_nxt;
		end
	end

	// Decoded straight from the state register, so glitch free
	assign resetb_core_h = (state == frame_ctrl_pkg::XRES_RELEASED);

endmodule

`default_nettype wire

//--- src/frame_ctrl_pkg.sv
`default_nettype none

package frame_ctrl_pkg;

	// Reset pad glitch filter
	localparam int XRES_FILTER_CYCLES = 8; // Clean high samples before release

	// Counter wide enough to reach XRES_FILTER_CYCLES itself
	localparam int XRES_CNT_W = $clog2(XRES_FILTER_CYCLES + 1);

	// Count value on the edge that takes the last qualifying sample
	localparam logic [XRES_CNT_W-1:0] XRES_CNT_LAST = XRES_CNT_W'(XRES_FILTER_CYCLES - 1);

	typedef enum logic [1:0] {
		XRES_ASSERTED = 2'd0, // Core held in reset
		XRES_QUALIFY  = 2'd1, // Counting high samples
		XRES_RELEASED = 2'd2  // Core running
	} xres_state_e;

endpackage

`default_nettype wire

//--- src/pad_cfg_pkg.sv
`default_nettype none

package pad_cfg_pkg;

	// User pad counts
	localparam int MPRJ_IO_PADS   = 38;   // All user pads, digital and analog
	localparam int MPRJ_IO_PADS_1 = 19;   // User area 1 share of the ring

	// Straight-through analog pads carved out of each user area
	localparam int ANALOG_PADS_1 = 5;
	localparam int ANALOG_PADS_2 = 6;
	localparam int ANALOG_PADS   = ANALOG_PADS_1 + ANALOG_PADS_2;

	localparam int DIGITAL_PADS  = MPRJ_IO_PADS - ANALOG_PADS;    // 27 GPIO cells
	localparam int AREA1_DIGITAL = MPRJ_IO_PADS_1 - ANALOG_PADS_1; // Digital pads below analog
	localparam int ANALOG_BASE   = MPRJ_IO_PADS_1 - ANALOG_PADS_1; // Pad index of mprj_analog[0]

	// Canonical drive modes, named by the raw dm code of each class
	typedef enum logic [2:0] {
		DM_ANALOG     = 3'd0, // Input buffer off, no drive
		DM_INPUT      = 3'd1, // Input only
		DM_OPEN_DRAIN = 3'd3, // Pulls low, floats high
		DM_STRONG     = 3'd6  // Push-pull
	} dm_e;

	// Folds all eight raw dm codes onto the four pad behaviours
	function automatic dm_e dm_decode(input logic [2:0] code);
		dm_e mode;
		case (code)
			3'd0: mode = DM_ANALOG;
			3'd2,
			3'd3: mode = DM_OPEN_DRAIN;
			3'd6,
			3'd7: mode = DM_STRONG;
			default: begin
				// Codes 1, 4 and 5 carry weak pulls on silicon, modelled as plain input
				mode = DM_INPUT;
			end
		endcase
		return mode;
	endfunction

endpackage

`default_nettype wire
